// ==== verilog/mips_id_pkg.sv ====
package mips_id_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J    = 6'h02, OP_JAL   = 6'h03,
		OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ = 6'h06, OP_BGTZ  = 6'h07,
		OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI = 6'h0a, OP_SLTIU = 6'h0b,
		OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI = 6'h0e, OP_LUI   = 6'h0f,
		OP_LB      = 6'h20, OP_LH     = 6'h21, OP_LWL  = 6'h22, OP_LW    = 6'h23,
		OP_LBU     = 6'h24, OP_LHU    = 6'h25, OP_LWR  = 6'h26,
		OP_SB      = 6'h28, OP_SH     = 6'h29, OP_SWL  = 6'h2a, OP_SW    = 6'h2b,
		OP_SWR     = 6'h2e
	} opcode_e;

	typedef enum logic [5:0] {
		FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03, FN_SLLV = 6'h04,
		FN_SRLV = 6'h06, FN_SRAV = 6'h07, FN_JR   = 6'h08, FN_JALR = 6'h09,
		FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB  = 6'h22, FN_SUBU = 6'h23,
		FN_AND  = 6'h24, FN_OR   = 6'h25, FN_XOR  = 6'h26, FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a, FN_SLTU = 6'h2b
	} funct_e;

	typedef enum logic [4:0] {
		RI_BLTZ = 5'h00, RI_BGEZ = 5'h01, RI_BLTZAL = 5'h10, RI_BGEZAL = 5'h11
	} regimm_e;

	typedef enum logic [7:0] {
		ALU_NOP    = 8'h00,
		ALU_AND    = 8'h24, ALU_OR     = 8'h25, ALU_XOR   = 8'h26, ALU_NOR  = 8'h27,
		ALU_SLL    = 8'h7c, ALU_SRL    = 8'h02, ALU_SRA   = 8'h03,
		ALU_SLT    = 8'h2a, ALU_SLTU   = 8'h2b, ALU_ADD   = 8'h20, ALU_ADDU = 8'h21,
		ALU_SUB    = 8'h22, ALU_SUBU   = 8'h23, ALU_ADDI  = 8'h55, ALU_ADDIU = 8'h56,
		ALU_J      = 8'h4f, ALU_JAL    = 8'h50, ALU_JALR  = 8'h09, ALU_JR   = 8'h08,
		ALU_BEQ    = 8'h51, ALU_BNE    = 8'h52, ALU_BGTZ  = 8'h54, ALU_BLEZ = 8'h53,
		ALU_BGEZ   = 8'h41, ALU_BGEZAL = 8'h4b, ALU_BLTZ  = 8'h40, ALU_BLTZAL = 8'h4a,
		ALU_LB     = 8'he0, ALU_LBU    = 8'he4, ALU_LH    = 8'he1, ALU_LHU  = 8'he5,
		ALU_LW     = 8'he3, ALU_LWL    = 8'he2, ALU_LWR   = 8'he6,
		ALU_SB     = 8'he8, ALU_SH     = 8'he9, ALU_SW    = 8'heb, ALU_SWL  = 8'hea,
		ALU_SWR    = 8'hee
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_NOP = 3'd0, SEL_LOGIC = 3'd1, SEL_SHIFT = 3'd2, SEL_ARITH = 3'd4,
		SEL_JUMP_BRANCH = 3'd6, SEL_LOAD_STORE = 3'd7
	} alu_sel_e;

	typedef enum logic [2:0] {
		IMM_NONE, IMM_ZERO, IMM_SIGN, IMM_UPPER, IMM_SHAMT
	} imm_kind_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_ALWAYS, BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_GEZ, BR_LTZ
	} branch_kind_e;

	typedef struct packed {
		logic      we;
		reg_addr_t waddr;
		word_t     wdata;
	} reg_wb_t;

	typedef struct packed {
		alu_op_e      aluop;
		alu_sel_e     alusel;
		logic         re1;
		reg_addr_t    raddr1;
		logic         re2;
		reg_addr_t    raddr2;
		reg_addr_t    waddr;
		logic         we;
		imm_kind_e    imm_kind;
		branch_kind_e branch_kind;
		logic         link;
		// jump target comes from reg1
		logic         reg_target;
		logic         inst_valid;
	} decode_t;

	typedef struct packed {
		alu_op_e   aluop;
		alu_sel_e  alusel;
		word_t     reg1;
		word_t     reg2;
		reg_addr_t waddr;
		logic      we;
		word_t     link_addr;
		logic      in_delayslot;
		logic      inst_valid;
	} id_ex_t;

	typedef struct packed {
		logic  branch_flag;
		word_t branch_target;
	} branch_t;

	localparam reg_addr_t LINK_REG   = 5'd31;
	localparam reg_addr_t ZERO_REG   = 5'd0;
	localparam id_ex_t    NOP_BUNDLE = '0;

endpackage

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  mips_id_pkg::reg_wb_t   wb_i,
	input  mips_id_pkg::reg_addr_t raddr1_i,
	input  mips_id_pkg::reg_addr_t raddr2_i,
	output mips_id_pkg::word_t     rdata1_o,
	output mips_id_pkg::word_t     rdata2_o
);
	import mips_id_pkg::*;

	word_t regs [32];

	// r0 is never written, so it keeps its reset value
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.we && wb_i.waddr != ZERO_REG) begin
			regs[wb_i.waddr] <= wb_i.wdata;
		end
	end

	// same-cycle write is not bypassed
	assign rdata1_o = regs[raddr1_i];
	assign rdata2_o = regs[raddr2_i];

	r0_reads_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
		(raddr1_i == ZERO_REG |-> rdata1_o == '0) and
		(raddr2_i == ZERO_REG |-> rdata2_o == '0));

endmodule

// ==== verilog/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
	input  mips_id_pkg::word_t   inst_i,
	output mips_id_pkg::decode_t dec_o
);
	import mips_id_pkg::*;

	logic [5:0] op;
	logic [5:0] funct;
	logic [4:0] shamt;
	reg_addr_t  rs;
	reg_addr_t  rt;
	reg_addr_t  rd;

	assign op    = inst_i[31:26];
	assign rs    = inst_i[25:21];
	assign rt    = inst_i[20:16];
	assign rd    = inst_i[15:11];
	assign shamt = inst_i[10:6];
	assign funct = inst_i[5:0];

	function automatic alu_op_e map_op(input logic [5:0] o, input logic [5:0] f,
			input logic [4:0] r);
		case (o)
			OP_SPECIAL: begin
				case (f)
					FN_SLL, FN_SLLV: return ALU_SLL;
					FN_SRL, FN_SRLV: return ALU_SRL;
					FN_SRA, FN_SRAV: return ALU_SRA;
					FN_AND:  return ALU_AND;
					FN_OR:   return ALU_OR;
					FN_XOR:  return ALU_XOR;
					FN_NOR:  return ALU_NOR;
					FN_SLT:  return ALU_SLT;
					FN_SLTU: return ALU_SLTU;
					FN_ADD:  return ALU_ADD;
					FN_ADDU: return ALU_ADDU;
					FN_SUB:  return ALU_SUB;
					FN_SUBU: return ALU_SUBU;
					FN_JR:   return ALU_JR;
					FN_JALR: return ALU_JALR;
					default: return ALU_NOP;
				endcase
			end
			OP_REGIMM: begin
				case (r)
					RI_BLTZ:   return ALU_BLTZ;
					RI_BGEZ:   return ALU_BGEZ;
					RI_BLTZAL: return ALU_BLTZAL;
					RI_BGEZAL: return ALU_BGEZAL;
					default:   return ALU_NOP;
				endcase
			end
			OP_ORI, OP_LUI: return ALU_OR;
			OP_ANDI:  return ALU_AND;
			OP_XORI:  return ALU_XOR;
			OP_SLTI:  return ALU_SLT;
			OP_SLTIU: return ALU_SLTU;
			OP_ADDI:  return ALU_ADDI;
			OP_ADDIU: return ALU_ADDIU;
			OP_J:     return ALU_J;
			OP_JAL:   return ALU_JAL;
			OP_BEQ:   return ALU_BEQ;
			OP_BNE:   return ALU_BNE;
			OP_BGTZ:  return ALU_BGTZ;
			OP_BLEZ:  return ALU_BLEZ;
			OP_LB:    return ALU_LB;
			OP_LBU:   return ALU_LBU;
			OP_LH:    return ALU_LH;
			OP_LHU:   return ALU_LHU;
			OP_LW:    return ALU_LW;
			OP_LWL:   return ALU_LWL;
			OP_LWR:   return ALU_LWR;
			OP_SB:    return ALU_SB;
			OP_SH:    return ALU_SH;
			OP_SW:    return ALU_SW;
			OP_SWL:   return ALU_SWL;
			OP_SWR:   return ALU_SWR;
			default:  return ALU_NOP;
		endcase
	endfunction

	function automatic alu_sel_e op_class(input alu_op_e a);
		case (a)
			ALU_AND, ALU_OR, ALU_XOR, ALU_NOR: return SEL_LOGIC;
			ALU_SLL, ALU_SRL, ALU_SRA: return SEL_SHIFT;
			ALU_SLT, ALU_SLTU, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
			ALU_ADDI, ALU_ADDIU: return SEL_ARITH;
			ALU_J, ALU_JAL, ALU_JR, ALU_JALR, ALU_BEQ, ALU_BNE, ALU_BGTZ, ALU_BLEZ,
			ALU_BGEZ, ALU_BGEZAL, ALU_BLTZ, ALU_BLTZAL: return SEL_JUMP_BRANCH;
			ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW, ALU_LWL, ALU_LWR,
			ALU_SB, ALU_SH, ALU_SW, ALU_SWL, ALU_SWR: return SEL_LOAD_STORE;
			default: return SEL_NOP;
		endcase
	endfunction

	always_comb begin
		dec_o        = '0;
		dec_o.raddr1 = rs;
		dec_o.raddr2 = rt;
		dec_o.waddr  = rd;
		case (op)
			OP_SPECIAL: begin
				case (funct)
					FN_SLL, FN_SRL, FN_SRA: begin
						// shamt goes out as operand 1
						dec_o.re2        = 1'b1;
						dec_o.imm_kind   = IMM_SHAMT;
						dec_o.we         = 1'b1;
						dec_o.inst_valid = (rs == ZERO_REG);
					end
					FN_SLLV, FN_SRLV, FN_SRAV, FN_AND, FN_OR, FN_XOR, FN_NOR,
					FN_SLT, FN_SLTU, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU: begin
						dec_o.re1        = 1'b1;
						dec_o.re2        = 1'b1;
						dec_o.we         = 1'b1;
						dec_o.inst_valid = (shamt == 5'd0);
					end
					FN_JR, FN_JALR: begin
						dec_o.re1         = 1'b1;
						dec_o.branch_kind = BR_ALWAYS;
						dec_o.reg_target  = 1'b1;
						dec_o.we          = (funct == FN_JALR);
						dec_o.link        = (funct == FN_JALR);
						dec_o.inst_valid  = 1'b1;
					end
					default: ;
				endcase
			end
			OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU: begin
				dec_o.re1        = 1'b1;
				dec_o.waddr      = rt;
				dec_o.we         = 1'b1;
				dec_o.inst_valid = 1'b1;
				if (op == OP_LUI)
					dec_o.imm_kind = IMM_UPPER;
				else if (op inside {OP_ORI, OP_ANDI, OP_XORI})
					dec_o.imm_kind = IMM_ZERO;
				else
					dec_o.imm_kind = IMM_SIGN;
			end
			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR: begin
				// partial-word loads merge into the old rt value
				dec_o.re1        = 1'b1;
				dec_o.re2        = (op == OP_LWL) || (op == OP_LWR);
				dec_o.waddr      = rt;
				dec_o.we         = 1'b1;
				dec_o.inst_valid = 1'b1;
			end
			OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR: begin
				dec_o.re1        = 1'b1;
				dec_o.re2        = 1'b1;
				dec_o.inst_valid = 1'b1;
			end
			OP_J, OP_JAL: begin
				dec_o.branch_kind = BR_ALWAYS;
				dec_o.waddr       = LINK_REG;
				dec_o.we          = (op == OP_JAL);
				dec_o.link        = (op == OP_JAL);
				dec_o.inst_valid  = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				dec_o.re1         = 1'b1;
				dec_o.re2         = 1'b1;
				dec_o.branch_kind = (op == OP_BEQ) ? BR_EQ : BR_NE;
				dec_o.inst_valid  = 1'b1;
			end
			OP_BGTZ, OP_BLEZ: begin
				dec_o.re1         = 1'b1;
				dec_o.branch_kind = (op == OP_BGTZ) ? BR_GTZ : BR_LEZ;
				dec_o.inst_valid  = 1'b1;
			end
			OP_REGIMM: begin
				dec_o.re1         = 1'b1;
				dec_o.waddr       = LINK_REG;
				dec_o.branch_kind = rt[0] ? BR_GEZ : BR_LTZ;
				dec_o.we          = (rt == RI_BGEZAL) || (rt == RI_BLTZAL);
				dec_o.link        = dec_o.we;
				dec_o.inst_valid  = rt inside {RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL};
			end
			default: ;
		endcase
		if (dec_o.inst_valid) begin
			dec_o.aluop  = map_op(op, funct, rt);
			dec_o.alusel = op_class(dec_o.aluop);
		end else begin
			dec_o = '0;
		end
	end

endmodule

// ==== verilog/operand_fetch.sv ====
`timescale 1ns/1ps

module operand_fetch (
	input  mips_id_pkg::decode_t   dec_i,
	input  mips_id_pkg::word_t     inst_i,
	input  mips_id_pkg::word_t     rdata1_i,
	input  mips_id_pkg::word_t     rdata2_i,
	input  mips_id_pkg::reg_wb_t   ex_fwd_i,
	input  mips_id_pkg::reg_wb_t   mem_fwd_i,
	input  mips_id_pkg::alu_op_e   ex_aluop_i,
	output mips_id_pkg::reg_addr_t raddr1_o,
	output mips_id_pkg::reg_addr_t raddr2_o,
	output mips_id_pkg::word_t     reg1_o,
	output mips_id_pkg::word_t     reg2_o,
	output logic                   stall_o
);
	import mips_id_pkg::*;

	word_t imm;
	logic  ex_is_load;

	always_comb begin
		case (dec_i.imm_kind)
			IMM_ZERO:  imm = {16'h0, inst_i[15:0]};
			IMM_SIGN:  imm = {{16{inst_i[15]}}, inst_i[15:0]};
			IMM_UPPER: imm = {inst_i[15:0], 16'h0};
			IMM_SHAMT: imm = {27'h0, inst_i[10:6]};
			default:   imm = '0;
		endcase
	end

	// execute first, then memory, then the register file
	function automatic word_t pick(input logic re, input reg_addr_t addr, input word_t rdata,
			input word_t imm_val, input reg_wb_t ex, input reg_wb_t mem);
		if (!re)
			return imm_val;
		if (ex.we && ex.waddr == addr)
			return ex.wdata;
		if (mem.we && mem.waddr == addr)
			return mem.wdata;
		return rdata;
	endfunction

	assign raddr1_o = dec_i.raddr1;
	assign raddr2_o = dec_i.raddr2;
	assign reg1_o   = pick(dec_i.re1, dec_i.raddr1, rdata1_i, imm, ex_fwd_i, mem_fwd_i);
	assign reg2_o   = pick(dec_i.re2, dec_i.raddr2, rdata2_i, imm, ex_fwd_i, mem_fwd_i);

	assign ex_is_load = ex_aluop_i inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU,
		ALU_LW, ALU_LWL, ALU_LWR};

	// load data only exists after memory, so wait one cycle
	always_comb begin
		stall_o = ex_is_load &&
			((dec_i.re1 && ex_fwd_i.waddr == dec_i.raddr1) ||
			 (dec_i.re2 && ex_fwd_i.waddr == dec_i.raddr2));
		no_stall_on_invalid: assert (!stall_o || dec_i.inst_valid);
	end

endmodule

// ==== verilog/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
	input  mips_id_pkg::decode_t dec_i,
	input  mips_id_pkg::word_t   pc_i,
	input  mips_id_pkg::word_t   inst_i,
	input  mips_id_pkg::word_t   reg1_i,
	input  mips_id_pkg::word_t   reg2_i,
	output mips_id_pkg::branch_t branch_o,
	output mips_id_pkg::word_t   link_addr_o
);
	import mips_id_pkg::*;

	word_t pc_plus4;
	word_t pc_plus8;
	word_t br_offset;
	word_t target;
	logic  taken;

	assign pc_plus4  = pc_i + 32'd4;
	assign pc_plus8  = pc_i + 32'd8;
	assign br_offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

	always_comb begin
		case (dec_i.branch_kind)
			BR_ALWAYS: taken = 1'b1;
			BR_EQ:     taken = (reg1_i == reg2_i);
			BR_NE:     taken = (reg1_i != reg2_i);
			BR_GTZ:    taken = !reg1_i[31] && (reg1_i != '0);
			BR_LEZ:    taken = reg1_i[31] || (reg1_i == '0);
			BR_GEZ:    taken = !reg1_i[31];
			BR_LTZ:    taken = reg1_i[31];
			default:   taken = 1'b0;
		endcase
	end

	always_comb begin
		if (dec_i.reg_target)
			target = reg1_i;
		else if (dec_i.branch_kind == BR_ALWAYS)
			target = {pc_plus4[31:28], inst_i[25:0], 2'b00};
		else
			target = pc_plus4 + br_offset;
	end

	// target reads zero when not taken
	assign branch_o.branch_flag   = taken;
	assign branch_o.branch_target = taken ? target : '0;
	assign link_addr_o            = dec_i.link ? pc_plus8 : '0;

endmodule

// ==== verilog/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  mips_id_pkg::decode_t dec_i,
	input  mips_id_pkg::word_t   reg1_i,
	input  mips_id_pkg::word_t   reg2_i,
	input  mips_id_pkg::word_t   link_addr_i,
	input  logic                 stall_i,
	output mips_id_pkg::id_ex_t  id_ex_o
);
	import mips_id_pkg::*;

	id_ex_t next_bundle;
	logic   is_branch;
	// next latched instruction sits in a delay slot
	logic   delayslot_q;

	assign is_branch = dec_i.inst_valid && (dec_i.branch_kind != BR_NONE);

	always_comb begin
		next_bundle.aluop        = dec_i.aluop;
		next_bundle.alusel       = dec_i.alusel;
		next_bundle.reg1         = reg1_i;
		next_bundle.reg2         = reg2_i;
		next_bundle.waddr        = dec_i.waddr;
		next_bundle.we           = dec_i.we;
		next_bundle.link_addr    = link_addr_i;
		next_bundle.in_delayslot = delayslot_q;
		next_bundle.inst_valid   = dec_i.inst_valid;
	end

	// a stall inserts a bubble, the slot flag waits for the replay
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			id_ex_o     <= NOP_BUNDLE;
			delayslot_q <= 1'b0;
		end else if (stall_i) begin
			id_ex_o <= NOP_BUNDLE;
		end else begin
			id_ex_o     <= next_bundle;
			delayslot_q <= is_branch;
		end
	end

	invalid_never_writes: assert property (@(posedge clk) disable iff (!arst_n_i)
		!id_ex_o.inst_valid |-> !id_ex_o.we);

endmodule

// ==== verilog/mips_id_top.sv ====
`timescale 1ns/1ps

module mips_id_top (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  mips_id_pkg::word_t   pc_i,
	input  mips_id_pkg::word_t   inst_i,
	input  mips_id_pkg::reg_wb_t ex_fwd_i,
	input  mips_id_pkg::alu_op_e ex_aluop_i,
	input  mips_id_pkg::reg_wb_t mem_fwd_i,
	input  mips_id_pkg::reg_wb_t wb_i,
	output mips_id_pkg::id_ex_t  id_ex_o,
	output mips_id_pkg::branch_t branch_o,
	output logic                 stall_o
);
	import mips_id_pkg::*;

	decode_t   dec;
	reg_addr_t raddr1;
	reg_addr_t raddr2;
	word_t     rdata1;
	word_t     rdata2;
	word_t     reg1;
	word_t     reg2;
	word_t     link_addr;

	reg_file i_reg_file (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.wb_i     (wb_i),
		.raddr1_i (raddr1),
		.raddr2_i (raddr2),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2)
	);

	inst_decoder i_inst_decoder (
		.inst_i (inst_i),
		.dec_o  (dec)
	);

	operand_fetch i_operand_fetch (
		.dec_i      (dec),
		.inst_i     (inst_i),
		.rdata1_i   (rdata1),
		.rdata2_i   (rdata2),
		.ex_fwd_i   (ex_fwd_i),
		.mem_fwd_i  (mem_fwd_i),
		.ex_aluop_i (ex_aluop_i),
		.raddr1_o   (raddr1),
		.raddr2_o   (raddr2),
		.reg1_o     (reg1),
		.reg2_o     (reg2),
		.stall_o    (stall_o)
	);

	branch_unit i_branch_unit (
		.dec_i       (dec),
		.pc_i        (pc_i),
		.inst_i      (inst_i),
		.reg1_i      (reg1),
		.reg2_i      (reg2),
		.branch_o    (branch_o),
		.link_addr_o (link_addr)
	);

	id_ex_reg i_id_ex_reg (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.dec_i       (dec),
		.reg1_i      (reg1),
		.reg2_i      (reg2),
		.link_addr_i (link_addr),
		.stall_i     (stall_o),
		.id_ex_o     (id_ex_o)
	);

endmodule

// ==== tests/id_checker.sv ====
`timescale 1ns/1ps

module id_checker (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  mips_id_pkg::word_t   pc_i,
	input  mips_id_pkg::word_t   inst_i,
	input  mips_id_pkg::reg_wb_t ex_fwd_i,
	input  mips_id_pkg::alu_op_e ex_aluop_i,
	input  mips_id_pkg::reg_wb_t mem_fwd_i,
	input  mips_id_pkg::reg_wb_t wb_i,
	input  mips_id_pkg::id_ex_t  id_ex_o,
	input  mips_id_pkg::branch_t branch_o,
	input  logic                 stall_o,
	output int                   checks_o,
	output int                   errors_o
);
	import mips_id_pkg::*;

	typedef struct packed {
		id_ex_t  bundle;
		branch_t br;
		logic    stall;
		logic    is_branch;
	} expect_t;

	word_t   shadow [32];
	id_ex_t  pending;
	logic    in_slot;
	expect_t exp_now;

	function automatic alu_op_e special_op(input logic [5:0] fn);
		case (fn)
			6'h00, 6'h04: return ALU_SLL;
			6'h02, 6'h06: return ALU_SRL;
			6'h03, 6'h07: return ALU_SRA;
			6'h08: return ALU_JR;
			6'h09: return ALU_JALR;
			6'h20: return ALU_ADD;
			6'h21: return ALU_ADDU;
			6'h22: return ALU_SUB;
			6'h23: return ALU_SUBU;
			6'h24: return ALU_AND;
			6'h25: return ALU_OR;
			6'h26: return ALU_XOR;
			6'h27: return ALU_NOR;
			6'h2a: return ALU_SLT;
			default: return ALU_SLTU;
		endcase
	endfunction

	function automatic alu_op_e main_op(input logic [5:0] op, input logic [4:0] rt);
		case (op)
			6'h01: begin
				case (rt)
					5'h00: return ALU_BLTZ;
					5'h01: return ALU_BGEZ;
					5'h10: return ALU_BLTZAL;
					default: return ALU_BGEZAL;
				endcase
			end
			6'h02: return ALU_J;
			6'h03: return ALU_JAL;
			6'h04: return ALU_BEQ;
			6'h05: return ALU_BNE;
			6'h06: return ALU_BLEZ;
			6'h07: return ALU_BGTZ;
			6'h08: return ALU_ADDI;
			6'h09: return ALU_ADDIU;
			6'h0a: return ALU_SLT;
			6'h0b: return ALU_SLTU;
			6'h0c: return ALU_AND;
			6'h0e: return ALU_XOR;
			6'h0d, 6'h0f: return ALU_OR;
			6'h20: return ALU_LB;
			6'h21: return ALU_LH;
			6'h22: return ALU_LWL;
			6'h23: return ALU_LW;
			6'h24: return ALU_LBU;
			6'h25: return ALU_LHU;
			6'h26: return ALU_LWR;
			6'h28: return ALU_SB;
			6'h29: return ALU_SH;
			6'h2a: return ALU_SWL;
			6'h2b: return ALU_SW;
			default: return ALU_SWR;
		endcase
	endfunction

	// expected bundle, branch and stall for one instruction
	function automatic expect_t predict(input word_t inst, input word_t pc, input reg_wb_t ex,
			input alu_op_e ex_op, input reg_wb_t mem, input word_t v_rs, input word_t v_rt,
			input logic slot);
		logic [5:0] op;
		logic [5:0] fn;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  wa;
		logic       ok;
		logic       use1;
		logic       use2;
		logic       we;
		logic       link;
		logic       taken;
		word_t      immv;
		word_t      a;
		word_t      b;
		word_t      tgt;
		word_t      pc4;
		alu_sel_e   sel;
		expect_t    e;
		op = inst[31:26];
		fn = inst[5:0];
		rs = inst[25:21];
		rt = inst[20:16];
		wa = inst[15:11];
		{ok, use1, use2, we, link, taken} = '0;
		immv = '0;
		tgt  = '0;
		sel  = SEL_NOP;
		pc4  = pc + 32'd4;
		a = (ex.we && ex.waddr == rs) ? ex.wdata :
			(mem.we && mem.waddr == rs) ? mem.wdata : v_rs;
		b = (ex.we && ex.waddr == rt) ? ex.wdata :
			(mem.we && mem.waddr == rt) ? mem.wdata : v_rt;
		case (op)
			6'h00: begin
				if (fn inside {6'h00, 6'h02, 6'h03}) begin
					ok   = (rs == 5'd0);
					use2 = 1'b1;
					we   = 1'b1;
					immv = {27'h0, inst[10:6]};
					sel  = SEL_SHIFT;
				end else if (fn inside {6'h04, 6'h06, 6'h07, [6'h20:6'h27], 6'h2a, 6'h2b}) begin
					ok   = (inst[10:6] == 5'd0);
					use1 = 1'b1;
					use2 = 1'b1;
					we   = 1'b1;
					sel  = (fn < 6'h08) ? SEL_SHIFT :
						(fn inside {[6'h24:6'h27]}) ? SEL_LOGIC : SEL_ARITH;
				end else if (fn inside {6'h08, 6'h09}) begin
					ok    = 1'b1;
					use1  = 1'b1;
					link  = fn[0];
					we    = fn[0];
					taken = 1'b1;
					tgt   = a;
					sel   = SEL_JUMP_BRANCH;
				end
			end
			6'h01: begin
				ok    = (rt & 5'b01110) == 5'd0;
				use1  = 1'b1;
				wa    = LINK_REG;
				link  = rt[4];
				we    = rt[4];
				taken = rt[0] ? ($signed(a) >= 0) : ($signed(a) < 0);
				sel   = SEL_JUMP_BRANCH;
			end
			6'h02, 6'h03: begin
				ok    = 1'b1;
				wa    = LINK_REG;
				link  = op[0];
				we    = op[0];
				taken = 1'b1;
				tgt   = {pc4[31:28], inst[25:0], 2'b00};
				sel   = SEL_JUMP_BRANCH;
			end
			6'h04, 6'h05, 6'h06, 6'h07: begin
				ok   = 1'b1;
				use1 = 1'b1;
				use2 = !op[1];
				case (op[1:0])
					2'd0: taken = (a == b);
					2'd1: taken = (a != b);
					2'd2: taken = ($signed(a) <= 0);
					default: taken = ($signed(a) > 0);
				endcase
				sel = SEL_JUMP_BRANCH;
			end
			6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
				ok   = 1'b1;
				use1 = 1'b1;
				we   = 1'b1;
				wa   = rt;
				sel  = op[2] ? SEL_LOGIC : SEL_ARITH;
				if (op == 6'h0f)
					immv = {inst[15:0], 16'h0};
				else if (op[2])
					immv = {16'h0, inst[15:0]};
				else
					immv = {{16{inst[15]}}, inst[15:0]};
			end
			6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26: begin
				ok   = 1'b1;
				use1 = 1'b1;
				use2 = (op == 6'h22) || (op == 6'h26);
				we   = 1'b1;
				wa   = rt;
				sel  = SEL_LOAD_STORE;
			end
			6'h28, 6'h29, 6'h2a, 6'h2b, 6'h2e: begin
				ok   = 1'b1;
				use1 = 1'b1;
				use2 = 1'b1;
				sel  = SEL_LOAD_STORE;
			end
			default: ;
		endcase
		// branch offset counts from the delay slot
		if (sel == SEL_JUMP_BRANCH && op inside {[6'h04:6'h07], 6'h01})
			tgt = pc4 + {{14{inst[15]}}, inst[15:0], 2'b00};
		e = '0;
		e.bundle.in_delayslot = slot;
		if (ok) begin
			e.bundle.aluop      = (op == 6'h00) ? special_op(fn) : main_op(op, rt);
			e.bundle.alusel     = sel;
			e.bundle.reg1       = use1 ? a : immv;
			e.bundle.reg2       = use2 ? b : immv;
			e.bundle.waddr      = wa;
			e.bundle.we         = we;
			e.bundle.link_addr  = link ? pc + 32'd8 : 32'd0;
			e.bundle.inst_valid = 1'b1;
			e.br.branch_flag    = taken;
			e.br.branch_target  = taken ? tgt : 32'd0;
			e.is_branch         = (sel == SEL_JUMP_BRANCH);
			e.stall = (ex_op inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW, ALU_LWL, ALU_LWR})
				&& ((use1 && ex.waddr == rs) || (use2 && ex.waddr == rt));
		end
		return e;
	endfunction

	task automatic compare(input string name, input logic [127:0] exp, input logic [127:0] got);
		checks_o++;
		if (exp !== got) begin
			errors_o++;
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	// inputs change on the falling edge, look a little later
	always @(negedge clk) begin
		#1;
		if (!arst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				shadow[i] = '0;
			end
			pending  = NOP_BUNDLE;
			in_slot  = 1'b0;
			checks_o = 0;
			errors_o = 0;
		end else begin
			compare("id_ex_o", pending, id_ex_o);
			exp_now = predict(inst_i, pc_i, ex_fwd_i, ex_aluop_i, mem_fwd_i,
				shadow[inst_i[25:21]], shadow[inst_i[20:16]], in_slot);
			compare("branch_o", exp_now.br, branch_o);
			compare("stall_o", exp_now.stall, stall_o);
			if (exp_now.stall) begin
				pending = NOP_BUNDLE;
			end else begin
				pending = exp_now.bundle;
				in_slot = exp_now.is_branch;
			end
			// written at the coming rising edge
			if (wb_i.we && wb_i.waddr != ZERO_REG)
				shadow[wb_i.waddr] = wb_i.wdata;
		end
	end

endmodule

// ==== tests/tb_mips_id.sv ====
`timescale 1ns/1ps

module tb_mips_id;
	import mips_id_pkg::*;

	localparam int N_RTYPE    = 40;
	localparam int N_IMM      = 40;
	localparam int N_FWD      = 8;
	localparam int N_LOADUSE  = 6;
	localparam int N_BR_REP   = 4;
	localparam int N_BAD      = 20;
	localparam int N_TESTS    = 6;
	localparam int TOTAL_CYCLES = 5 + 31 + N_RTYPE + N_IMM + 2 * N_FWD + 2 * N_LOADUSE
		+ 12 * N_BR_REP * 2 + N_BAD + 2 * N_TESTS;
	localparam logic [5:0] RFN [16] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h20,
		6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
	localparam logic [5:0] IMM_OPS [8] = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

	logic        clk;
	logic        arst_n_i;
	word_t       pc_i;
	word_t       inst_i;
	reg_wb_t     ex_fwd_i;
	alu_op_e     ex_aluop_i;
	reg_wb_t     mem_fwd_i;
	reg_wb_t     wb_i;
	id_ex_t      id_ex_o;
	branch_t     branch_o;
	logic        stall_o;
	int          checks;
	int          errors;
	int          err_before;
	int          tests_failed;
	int          test_num;
	logic [31:0] seed;

	mips_id_top i_dut (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.pc_i       (pc_i),
		.inst_i     (inst_i),
		.ex_fwd_i   (ex_fwd_i),
		.ex_aluop_i (ex_aluop_i),
		.mem_fwd_i  (mem_fwd_i),
		.wb_i       (wb_i),
		.id_ex_o    (id_ex_o),
		.branch_o   (branch_o),
		.stall_o    (stall_o)
	);

	id_checker i_checker (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.pc_i       (pc_i),
		.inst_i     (inst_i),
		.ex_fwd_i   (ex_fwd_i),
		.ex_aluop_i (ex_aluop_i),
		.mem_fwd_i  (mem_fwd_i),
		.wb_i       (wb_i),
		.id_ex_o    (id_ex_o),
		.branch_o   (branch_o),
		.stall_o    (stall_o),
		.checks_o   (checks),
		.errors_o   (errors)
	);

	always #2 clk = ~clk;

	function logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic is_kept_opcode(input logic [5:0] op);
		return op <= 6'h0f || op inside {[6'h20:6'h26], [6'h28:6'h2b], 6'h2e};
	endfunction

	function automatic logic is_kept_funct(input logic [5:0] fn);
		return fn inside {6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09,
			[6'h20:6'h27], 6'h2a, 6'h2b};
	endfunction

	function automatic word_t rtype(input logic [5:0] fn);
		logic [31:0] r;
		r = next_rand();
		// shift-by-amount has rs zero, the rest have shamt zero
		if (fn < 6'h04)
			return {6'h00, 5'd0, r[20:16], r[15:11], r[10:6], fn};
		return {6'h00, r[25:21], r[20:16], r[15:11], 5'd0, fn};
	endfunction

	// present one instruction for one cycle
	task automatic issue(input word_t inst);
		logic [31:0] r;
		r      = next_rand();
		inst_i = inst;
		pc_i   = {r[31:2], 2'b00};
		@(negedge clk);
	endtask

	task automatic close_test(input string name);
		ex_fwd_i   = '0;
		mem_fwd_i  = '0;
		ex_aluop_i = ALU_NOP;
		wb_i       = '0;
		issue(32'h0);
		issue(32'h0);
		test_num++;
		if (errors != err_before)
			tests_failed++;
		$display("test %0d %s: %s, %0d errors", test_num, name,
			(errors == err_before) ? "pass" : "fail", errors - err_before);
		err_before = errors;
	endtask

	initial begin
		#(TOTAL_CYCLES * 4 + 200);
		$display("timeout: the tests did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [31:0] v;
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  other;
		clk = 1'b0;
		arst_n_i = 1'b0;
		pc_i = '0;
		inst_i = '0;
		ex_fwd_i = '0;
		ex_aluop_i = ALU_NOP;
		mem_fwd_i = '0;
		wb_i = '0;
		seed = 32'h7a2;
		err_before = 0;
		tests_failed = 0;
		test_num = 0;
		repeat (5) @(negedge clk);
		arst_n_i = 1'b1;

		for (int i = 1; i < 32; i++) begin
			wb_i = '{1'b1, 5'(i), next_rand()};
			issue(32'h0);
		end
		wb_i = '0;
		for (int i = 0; i < N_RTYPE; i++) begin
			r = next_rand();
			issue(rtype(RFN[r[3:0]]));
		end
		close_test("register and R-type decode");

		for (int i = 0; i < N_IMM; i++) begin
			r = next_rand();
			issue({IMM_OPS[r[2:0]], r[25:0]});
		end
		close_test("immediate operands");

		for (int i = 0; i < N_FWD; i++) begin
			r  = next_rand();
			rs = (i == 0) ? 5'd0 : r[25:21];
			rt = r[20:16];
			ex_fwd_i  = '{1'b1, rs, next_rand()};
			mem_fwd_i = '{1'b1, rs, next_rand()};
			issue({6'h00, rs, rt, r[15:11], 5'd0, 6'h21});
			ex_fwd_i  = '0;
			mem_fwd_i = '{1'b1, rt, next_rand()};
			issue({6'h00, rs, rt, r[15:11], 5'd0, 6'h21});
		end
		close_test("forwarding priority");

		for (int i = 0; i < N_LOADUSE; i++) begin
			r  = next_rand();
			rs = r[25:21];
			rt = r[20:16];
			// a destination that neither source uses
			other = rs + 5'd1;
			if (other == rt)
				other = other + 5'd1;
			ex_aluop_i = (i % 3 == 2) ? ALU_ADDU : ALU_LW;
			ex_fwd_i   = '{1'b1, (i % 3 == 1) ? other : rs, next_rand()};
			issue({6'h00, rs, rt, r[15:11], 5'd0, 6'h21});
			ex_aluop_i = ALU_NOP;
			ex_fwd_i   = '0;
			issue({6'h00, rs, rt, r[15:11], 5'd0, 6'h21});
		end
		close_test("load-use stall");

		for (int k = 0; k < 12; k++) begin
			for (int rep = 0; rep < N_BR_REP; rep++) begin
				r  = next_rand();
				rs = r[25:21];
				rt = rep[0] ? rs : r[20:16];
				v  = (rep == 0) ? 32'd0 : next_rand();
				ex_fwd_i = '{1'b1, rs, v};
				case (k)
					0: op = 6'h04;
					1: op = 6'h05;
					2: op = 6'h06;
					3: op = 6'h07;
					8: op = 6'h02;
					9: op = 6'h03;
					10, 11: op = 6'h00;
					default: op = 6'h01;
				endcase
				if (k >= 4 && k <= 7)
					rt = {k[1], 3'b000, k[0]};
				if (k == 2 || k == 3)
					rt = 5'd0;
				if (k >= 10)
					issue({op, rs, 5'd0, r[15:11], 5'd0, 5'b00100, k[0]});
				else if (k >= 8)
					issue({op, r[25:0]});
				else
					issue({op, rs, rt, r[15:0]});
				ex_fwd_i = '0;
				issue(rtype(6'h21));
			end
		end
		close_test("branches and jumps");

		for (int i = 0; i < N_BAD; i++) begin
			r = next_rand();
			op = r[31:26];
			while (is_kept_opcode(op)) begin
				r  = next_rand();
				op = r[31:26];
			end
			if (i[0] && !is_kept_funct(r[5:0]))
				issue({6'h00, r[25:6], r[5:0]});
			else
				issue({op, r[25:0]});
		end
		close_test("unmatched encodings");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			test_num, tests_failed, checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== list.f ====
verilog/mips_id_pkg.sv
verilog/reg_file.sv
verilog/inst_decoder.sv
verilog/operand_fetch.sv
verilog/branch_unit.sv
verilog/id_ex_reg.sv
verilog/mips_id_top.sv
tests/id_checker.sv
tests/tb_mips_id.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the decode stage testbench, the log decides the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module tb_mips_id \
	-o sim_mips_id > sim.log 2>&1 &&
	./obj_dir/sim_mips_id >> sim.log 2>&1 ||
	echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
